// File: source/corr_pkg.sv
package corr_pkg;

   //------------------------------------------------------------
   // Array sizes and accumulator range
   //------------------------------------------------------------
   localparam int N_ANT  = 24;
   localparam int N_PAIR = 12;
   localparam int ACC_W  = 12;

   // Signed saturation limits, 2047 and -2048 for 12 bits
   localparam int ACC_MAX = (1 << (ACC_W - 1)) - 1;
   localparam int ACC_MIN = -(1 << (ACC_W - 1));

   // Pair address within one pass
   typedef logic [3:0] pair_idx_t;

   // Bank bit on top of the pair address
   typedef logic [4:0] ram_adr_t;

   // Both banks of one accumulator array
   localparam int RAM_DEPTH = 2 ** $bits(ram_adr_t);

   // Antenna index into the sample vectors
   typedef logic [$clog2(N_ANT)-1:0] ant_idx_t;

   typedef struct packed {
      ant_idx_t a;
      ant_idx_t b;
   } pair_ent_t;

   // Fixed pair table, antenna a against antenna b
   localparam pair_ent_t PAIR_TABLE [N_PAIR] = '{
      '{a: 5'd0,  b: 5'd1},
      '{a: 5'd2,  b: 5'd3},
      '{a: 5'd4,  b: 5'd5},
      '{a: 5'd6,  b: 5'd7},
      '{a: 5'd8,  b: 5'd9},
      '{a: 5'd10, b: 5'd11},
      '{a: 5'd12, b: 5'd13},
      '{a: 5'd14, b: 5'd15},
      '{a: 5'd16, b: 5'd17},
      '{a: 5'd18, b: 5'd19},
      '{a: 5'd20, b: 5'd21},
      '{a: 5'd22, b: 5'd23}
   };

   //------------------------------------------------------------
   // Pipeline payloads
   //------------------------------------------------------------
   typedef struct packed {
      logic go;  // Sample slot was enabled
      logic ar;  // Real bit of antenna a
      logic br;  // Real bit of antenna b
      logic bi;  // Imaginary bit of antenna b
   } ant_bits_t;

   typedef struct packed {
      logic signed [ACC_W-1:0] cos_v;
      logic signed [ACC_W-1:0] sin_v;
   } acc_pair_t;

   typedef struct packed {
      logic      valid;
      ram_adr_t  adr;
      acc_pair_t acc;
   } wr_req_t;

endpackage

// File: source/pair_select.sv
`timescale 1ns/100ps

module pair_select
   import corr_pkg::*;
(
   input  logic             clk_x,
   input  logic             rst,
   input  logic             en_i,
   input  logic [N_ANT-1:0] re_i,
   input  logic [N_ANT-1:0] im_i,
   output pair_idx_t        adr_o,
   output logic             wrap_o,
   output ant_bits_t        bits_o
);

   //------------------------------------------------------------
   // Pair address counter
   //------------------------------------------------------------
   pair_idx_t adr_q;
   logic      last;

   // Last pair of the pass
   assign last = (adr_q == pair_idx_t'(N_PAIR - 1));

   always_ff @(posedge clk_x) begin
      if (rst) begin
         adr_q <= '0;
      end else if (en_i) begin
         // Wrap back to pair 0 after the last pair
         adr_q <= last ? '0 : adr_q + 4'd1;
      end
   end

   assign adr_o  = adr_q;
   assign wrap_o = last;

   //------------------------------------------------------------
   // Pair lookup and sample capture
   //------------------------------------------------------------
   pair_ent_t ent;
   logic      go_q;
   logic      ar_q;
   logic      br_q;
   logic      bi_q;

   assign ent = PAIR_TABLE[adr_q];

   // Go marks an enabled slot one cycle later
   always_ff @(posedge clk_x) begin
      if (rst) begin
         go_q <= 1'b0;
      end else begin
         go_q <= en_i;
      end
   end

   // Sample bits, aligned with the RAM read data
   always_ff @(posedge clk_x) begin
      ar_q <= re_i[ent.a];
      br_q <= re_i[ent.b];
      bi_q <= im_i[ent.b];
   end

   assign bits_o = '{go: go_q, ar: ar_q, br: br_q, bi: bi_q};

endmodule

// File: source/bank_ctrl.sv
`timescale 1ns/100ps

module bank_ctrl (
   input  logic clk_x,
   input  logic rst,
   input  logic en_i,
   input  logic sw_i,
   input  logic wrap_i,
   output logic bank_o,
   output logic bank_n_o,
   output logic clear_o
);

   //------------------------------------------------------------
   // Wrap and swap decode
   //------------------------------------------------------------
   logic pend_q;
   logic bank_q;
   logic clear_q;
   logic wrap_en;
   logic swap;

   // Wrap only counts on an enabled cycle
   assign wrap_en = en_i & wrap_i;

   // Swap on a pending request, or on a pulse landing on the wrap
   assign swap = wrap_en & (sw_i | pend_q);

   //------------------------------------------------------------
   // Bank state
   //------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         pend_q  <= 1'b0;
         bank_q  <= 1'b0;
         // Very first pass also starts from zero
         clear_q <= 1'b1;
      end else if (swap) begin
         pend_q  <= 1'b0;
         bank_q  <= ~bank_q;
         // Next full pass overwrites old sums
         clear_q <= 1'b1;
      end else begin
         // Remember a switch pulse until the wrap
         if (sw_i) begin
            pend_q <= 1'b1;
         end
         // Clear pass is over once all pairs were visited
         if (wrap_en && clear_q) begin
            clear_q <= 1'b0;
         end
      end
   end

   //------------------------------------------------------------
   // Outputs
   //------------------------------------------------------------
   assign bank_o   = bank_q;
   // Bus side reads the bank not being accumulated
   assign bank_n_o = ~bank_q;
   assign clear_o  = clear_q;

endmodule

// File: source/cos_sin_mac.sv
`timescale 1ns/100ps

module cos_sin_mac
   import corr_pkg::*;
(
   input  logic      clk_x,
   input  logic      rst,
   input  ant_bits_t bits_i,
   input  ram_adr_t  adr_i,
   input  acc_pair_t acc_i,
   output wr_req_t   wr_o,
   output logic      ovf_cos_o,
   output logic      ovf_sin_o
);

   //------------------------------------------------------------
   // One-bit products
   //------------------------------------------------------------
   logic cos_up;
   logic sin_up;

   // Equal sign bits give +1, else -1
   assign cos_up = ~(bits_i.ar ^ bits_i.br);
   assign sin_up = ~(bits_i.ar ^ bits_i.bi);

   //------------------------------------------------------------
   // Saturating add
   //------------------------------------------------------------
   logic                    cos_clip;
   logic                    sin_clip;
   logic signed [ACC_W-1:0] cos_nxt;
   logic signed [ACC_W-1:0] sin_nxt;

   // Step of one clips only at the rail it points to
   assign cos_clip = cos_up ? (acc_i.cos_v == ACC_MAX) : (acc_i.cos_v == ACC_MIN);
   assign sin_clip = sin_up ? (acc_i.sin_v == ACC_MAX) : (acc_i.sin_v == ACC_MIN);

   // Clipped value stays on the rail
   assign cos_nxt = cos_clip ? acc_i.cos_v :
                    cos_up   ? acc_i.cos_v + ACC_W'(1) : acc_i.cos_v - ACC_W'(1);
   assign sin_nxt = sin_clip ? acc_i.sin_v :
                    sin_up   ? acc_i.sin_v + ACC_W'(1) : acc_i.sin_v - ACC_W'(1);

   //------------------------------------------------------------
   // Write request and sticky flags
   //------------------------------------------------------------
   logic      valid_q;
   ram_adr_t  adr_q;
   acc_pair_t acc_q;
   logic      ovf_cos_q;
   logic      ovf_sin_q;

   always_ff @(posedge clk_x) begin
      if (rst) begin
         valid_q   <= 1'b0;
         ovf_cos_q <= 1'b0;
         ovf_sin_q <= 1'b0;
      end else begin
         valid_q <= bits_i.go;
         // Sticky until reset
         if (bits_i.go && cos_clip) ovf_cos_q <= 1'b1;
         if (bits_i.go && sin_clip) ovf_sin_q <= 1'b1;
      end
   end

   // Payload only moves on enabled slots
   always_ff @(posedge clk_x) begin
      if (bits_i.go) begin
         adr_q <= adr_i;
         acc_q <= '{cos_v: cos_nxt, sin_v: sin_nxt};
      end
   end

   assign wr_o      = '{valid: valid_q, adr: adr_q, acc: acc_q};
   assign ovf_cos_o = ovf_cos_q;
   assign ovf_sin_o = ovf_sin_q;

endmodule

// File: source/visibility_ram.sv
`timescale 1ns/100ps

module visibility_ram
   import corr_pkg::*;
(
   input  logic      clk_x,
   input  logic      rst,
   input  logic      en_i,
   input  pair_idx_t adr_i,
   input  logic      bank_i,
   input  logic      clear_i,
   input  wr_req_t   wr_i,
   input  ram_adr_t  bus_adr_i,
   output acc_pair_t rd_o,
   output ram_adr_t  rd_adr_o,
   output acc_pair_t bus_q_o
);

   //------------------------------------------------------------
   // Accumulator storage
   //------------------------------------------------------------
   // Lower half is bank 0, upper half bank 1
   logic signed [ACC_W-1:0] cos_mem [RAM_DEPTH];
   logic signed [ACC_W-1:0] sin_mem [RAM_DEPTH];

   ram_adr_t rd_adr;

   // Active bank selects the half being accumulated
   assign rd_adr = {bank_i, adr_i};

   //------------------------------------------------------------
   // Pipeline read port
   //------------------------------------------------------------
   acc_pair_t rd_q;
   ram_adr_t  rd_adr_q;

   always_ff @(posedge clk_x) begin
      if (!rst && en_i) begin
         // Clear pass feeds zero into the MAC
         if (clear_i) begin
            rd_q <= '0;
         end else begin
            rd_q <= '{cos_v: cos_mem[rd_adr], sin_v: sin_mem[rd_adr]};
         end
         // Carried along for the write-back
         rd_adr_q <= rd_adr;
      end
   end

   assign rd_o     = rd_q;
   assign rd_adr_o = rd_adr_q;

   //------------------------------------------------------------
   // Write-back port
   //------------------------------------------------------------
   // Two cycles after the read of the same word
   always_ff @(posedge clk_x) begin
      if (!rst && wr_i.valid) begin
         cos_mem[wr_i.adr] <= wr_i.acc.cos_v;
         sin_mem[wr_i.adr] <= wr_i.acc.sin_v;
      end
   end

   //------------------------------------------------------------
   // Bus read port
   //------------------------------------------------------------
   // Asynchronous read, registered in the bus block
   assign bus_q_o = '{cos_v: cos_mem[bus_adr_i], sin_v: sin_mem[bus_adr_i]};

endmodule

// File: source/vis_bus_read.sv
`timescale 1ns/100ps

module vis_bus_read
   import corr_pkg::*;
(
   input  logic             clk_x,
   input  logic             rst,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             bst_i,
   input  logic [4:0]       adr_i,
   input  logic             bank_n_i,
   input  acc_pair_t        bus_q_i,
   output ram_adr_t         bus_adr_o,
   output logic             ack_o,
   output logic [ACC_W-1:0] dat_o
);

   typedef enum logic [1:0] {
      BUS_IDLE = 2'd0,
      BUS_WAIT = 2'd1,
      BUS_READ = 2'd2
   } bus_state_t;

   bus_state_t state_q;
   logic       req;

   assign req = cyc_i & stb_i;

   //------------------------------------------------------------
   // Bus FSM
   //------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst || !cyc_i) begin
         // Dropping the cycle ends any transfer
         state_q <= BUS_IDLE;
      end else begin
         case (state_q)
            BUS_IDLE: if (req) state_q <= BUS_READ;
            BUS_WAIT: if (stb_i) state_q <= BUS_READ;
            // Burst keeps acking, address comes a cycle early
            BUS_READ: state_q <= (bst_i && stb_i) ? BUS_READ : BUS_WAIT;
            default:  state_q <= BUS_IDLE;
         endcase
      end
   end

   assign ack_o = (state_q == BUS_READ);

   //------------------------------------------------------------
   // Read data
   //------------------------------------------------------------
   // Pair field plus the bank not being accumulated
   assign bus_adr_o = {bank_n_i, adr_i[3:0]};

   // Bit 4 picks sine over cosine
   always_ff @(posedge clk_x) begin
      if (req) begin
         dat_o <= adr_i[4] ? bus_q_i.sin_v : bus_q_i.cos_v;
      end
   end

endmodule

// File: source/correlator_top.sv
`timescale 1ns/100ps

module correlator_top
   import corr_pkg::*;
(
   input  logic             clk_x,
   input  logic             rst,

   // Antenna samples
   input  logic             en_i,
   input  logic [N_ANT-1:0] re_i,
   input  logic [N_ANT-1:0] im_i,
   input  logic             sw_i,

   // Read bus
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             bst_i,
   input  logic [4:0]       adr_i,
   output logic             ack_o,
   output logic [ACC_W-1:0] dat_o,

   // Sticky saturation flags
   output logic             overflow_cos_o,
   output logic             overflow_sin_o
);

   //------------------------------------------------------------
   // Internal nets
   //------------------------------------------------------------
   pair_idx_t pair_adr;
   logic      wrap;
   ant_bits_t bits;
   logic      bank;
   logic      bank_n;
   logic      clear;
   acc_pair_t rd_acc;
   ram_adr_t  rd_adr;
   wr_req_t   wr_req;
   ram_adr_t  bus_adr;
   acc_pair_t bus_q;

   //------------------------------------------------------------
   // Correlator pipeline
   //------------------------------------------------------------
   // Stage 0, pair address and sample capture
   pair_select u_pair_select (
      .clk_x  (clk_x),
      .rst    (rst),
      .en_i   (en_i),
      .re_i   (re_i),
      .im_i   (im_i),
      .adr_o  (pair_adr),
      .wrap_o (wrap),
      .bits_o (bits)
   );

   bank_ctrl u_bank_ctrl (
      .clk_x    (clk_x),
      .rst      (rst),
      .en_i     (en_i),
      .sw_i     (sw_i),
      .wrap_i   (wrap),
      .bank_o   (bank),
      .bank_n_o (bank_n),
      .clear_o  (clear)
   );

   // Stages 1 and 3, read and write-back
   visibility_ram u_visibility_ram (
      .clk_x     (clk_x),
      .rst       (rst),
      .en_i      (en_i),
      .adr_i     (pair_adr),
      .bank_i    (bank),
      .clear_i   (clear),
      .wr_i      (wr_req),
      .bus_adr_i (bus_adr),
      .rd_o      (rd_acc),
      .rd_adr_o  (rd_adr),
      .bus_q_o   (bus_q)
   );

   // Stage 2, multiply-accumulate
   cos_sin_mac u_cos_sin_mac (
      .clk_x     (clk_x),
      .rst       (rst),
      .bits_i    (bits),
      .adr_i     (rd_adr),
      .acc_i     (rd_acc),
      .wr_o      (wr_req),
      .ovf_cos_o (overflow_cos_o),
      .ovf_sin_o (overflow_sin_o)
   );

   //------------------------------------------------------------
   // Bus side
   //------------------------------------------------------------
   vis_bus_read u_vis_bus_read (
      .clk_x     (clk_x),
      .rst       (rst),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .bst_i     (bst_i),
      .adr_i     (adr_i),
      .bank_n_i  (bank_n),
      .bus_q_i   (bus_q),
      .bus_adr_o (bus_adr),
      .ack_o     (ack_o),
      .dat_o     (dat_o)
   );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
   output logic clk_x
);

   // 8 ns period
   localparam real HALF_NS = 4.0;

   // Starts low, first rising edge after half a period
   initial begin
      clk_x = 1'b0;
   end

   always begin
      #(HALF_NS);
      clk_x = ~clk_x;
   end

endmodule

// File: tb/correlator_tb.sv
`timescale 1ns/100ps

module correlator_tb;

   localparam int NPAIR   = 12;
   localparam int SAT_MAX = 2047;
   localparam int SAT_MIN = -2048;
   // Saturation test is 2100 passes of 12 pairs and the rest about 1300 cycles
   // so roughly 26500 cycles with half again on top
   localparam int CYCLE_LIMIT = 40000;

   logic        clk_x;
   logic        rst;
   logic        en_i;
   logic [23:0] re_i;
   logic [23:0] im_i;
   logic        sw_i;
   logic        cyc_i;
   logic        stb_i;
   logic        bst_i;
   logic [4:0]  adr_i;
   logic        ack_o;
   logic [11:0] dat_o;
   logic        overflow_cos_o;
   logic        overflow_sin_o;

   int          errors;
   int          checks;
   int          cycles;
   logic [31:0] lfsr;
   bit          sat_mode;

   // Reference model sums per bank and pair
   int cos_sum [2][NPAIR];
   int sin_sum [2][NPAIR];
   int m_pair;
   int m_bank;
   bit m_clear;
   bit m_pend;
   bit m_ovf_cos;
   bit m_ovf_sin;

   tb_clock u_clock (.clk_x(clk_x));

   correlator_top dut (
      .clk_x          (clk_x),
      .rst            (rst),
      .en_i           (en_i),
      .re_i           (re_i),
      .im_i           (im_i),
      .sw_i           (sw_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .bst_i          (bst_i),
      .adr_i          (adr_i),
      .ack_o          (ack_o),
      .dat_o          (dat_o),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   //------------------------------------------------------------
   // Random source
   //------------------------------------------------------------
   // Taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic rand_bit();
      lfsr = lfsr_next(lfsr);
      return lfsr[0];
   endfunction

   function automatic logic [23:0] rand_word();
      logic [23:0] w;
      int          i;
      for (i = 0; i < 24; i++) begin
         w[i] = rand_bit();
      end
      return w;
   endfunction

   // About one slot in four left empty when gaps are on
   function automatic logic pick_en(input bit gaps);
      logic b0;
      logic b1;
      b0 = rand_bit();
      b1 = rand_bit();
      return gaps ? (b0 | b1) : 1'b1;
   endfunction

   //------------------------------------------------------------
   // Reference model
   //------------------------------------------------------------
   function automatic int clamp(input int v);
      if (v > SAT_MAX) return SAT_MAX;
      if (v < SAT_MIN) return SAT_MIN;
      return v;
   endfunction

   task automatic model_update(input logic en, input logic [23:0] re, input logic [23:0] im,
                               input logic sw);
      int a;
      int b;
      int c_new;
      int s_new;
      bit wrap;
      // Pair p correlates antennas 2p and 2p+1
      a = 2 * m_pair;
      b = a + 1;
      if (en) begin
         if (m_clear) begin
            cos_sum[m_bank][m_pair] = 0;
            sin_sum[m_bank][m_pair] = 0;
         end
         // Equal signs give +1
         c_new = cos_sum[m_bank][m_pair] + ((re[a] == re[b]) ? 1 : -1);
         s_new = sin_sum[m_bank][m_pair] + ((re[a] == im[b]) ? 1 : -1);
         if (c_new != clamp(c_new)) m_ovf_cos = 1'b1;
         if (s_new != clamp(s_new)) m_ovf_sin = 1'b1;
         cos_sum[m_bank][m_pair] = clamp(c_new);
         sin_sum[m_bank][m_pair] = clamp(s_new);
      end
      // Swap at an enabled wrap with a request pending or arriving
      wrap = en && (m_pair == NPAIR - 1);
      if (wrap && (sw || m_pend)) begin
         m_pend  = 1'b0;
         m_bank  = 1 - m_bank;
         m_clear = 1'b1;
      end else begin
         if (sw) m_pend = 1'b1;
         if (wrap) m_clear = 1'b0;
      end
      if (en) m_pair = wrap ? 0 : m_pair + 1;
   endtask

   // Value the bus must return from the bank not accumulating
   function automatic int model_value(input logic [4:0] adr);
      int bank;
      bank = 1 - m_bank;
      return adr[4] ? sin_sum[bank][adr[3:0]] : cos_sum[bank][adr[3:0]];
   endfunction

   function automatic logic [4:0] addr_of(input int i);
      return {i >= NPAIR, 4'(i % NPAIR)};
   endfunction

   //------------------------------------------------------------
   // Stimulus and checks
   //------------------------------------------------------------
   task automatic check_value(input string name, input int expected, input int actual);
      checks++;
      assert (expected == actual) else begin
         $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_flags(input string name, input bit exp_cos, input bit exp_sin);
      check_value({name, " cos flag"}, int'(exp_cos), int'(overflow_cos_o));
      check_value({name, " sin flag"}, int'(exp_sin), int'(overflow_sin_o));
   endtask

   // One sample slot driven 1 ns after the edge
   task automatic slot(input logic en, input logic sw);
      logic [23:0] re;
      logic [23:0] im;
      re = sat_mode ? '1 : rand_word();
      im = sat_mode ? '0 : rand_word();
      @(posedge clk_x);
      #1;
      en_i = en;
      re_i = re;
      im_i = im;
      sw_i = sw;
      model_update(en, re, im, sw);
   endtask

   task automatic run_passes(input int passes, input bit gaps);
      int   done;
      logic en;
      done = 0;
      while (done < passes * NPAIR) begin
         en = pick_en(gaps);
         slot(en, 1'b0);
         if (en) done++;
      end
   endtask

   // Pulse sw_i mid pass or right on the wrap and wait for the swap
   task automatic swap_banks(input bit on_wrap, input bit gaps);
      int start;
      start = m_bank;
      if (on_wrap) begin
         while (m_pair != NPAIR - 1) slot(pick_en(gaps), 1'b0);
      end
      slot(1'b1, 1'b1);
      while (m_bank == start) slot(pick_en(gaps), 1'b0);
      // Last write-backs land two cycles after the wrap
      repeat (4) slot(1'b0, 1'b0);
   endtask

   task automatic quiet_bus(input logic cyc, input logic stb);
      cyc_i = cyc;
      stb_i = stb;
      repeat (3) begin
         @(posedge clk_x);
         #1;
         check_value("idle ack", 0, int'(ack_o));
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
   endtask

   task automatic read_word(input logic [4:0] adr, input string name, input int expected);
      bit got;
      int n;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      bst_i = 1'b0;
      adr_i = adr;
      got   = 1'b0;
      n     = 0;
      while (!got && n < 4) begin
         @(posedge clk_x);
         #1;
         got = ack_o;
         n++;
      end
      assert (got) else begin
         $display("%s: no ack within 4 cycles for address %0d", name, adr);
         errors++;
      end
      if (got) check_value(name, expected, int'($signed(dat_o)));
      // Back to idle before the next request
      cyc_i = 1'b0;
      stb_i = 1'b0;
      @(posedge clk_x);
      #1;
   endtask

   task automatic read_all(input string name);
      int i;
      for (i = 0; i < 2 * NPAIR; i++) begin
         read_word(addr_of(i), name, model_value(addr_of(i)));
      end
   endtask

   // Address order steps by 7 to visit all 24 words
   task automatic read_burst(input string name);
      logic [4:0] prev;
      int         i;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      bst_i = 1'b1;
      adr_i = addr_of(0);
      for (i = 0; i < 2 * NPAIR; i++) begin
         prev = adr_i;
         @(posedge clk_x);
         #1;
         checks++;
         assert (ack_o) else begin
            $display("%s: ack missing on burst beat %0d", name, i);
            errors++;
         end
         // Data belongs to the address of the previous cycle
         check_value(name, model_value(prev), int'($signed(dat_o)));
         adr_i = addr_of((i + 1) * 7 % (2 * NPAIR));
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      bst_i = 1'b0;
   endtask

   //------------------------------------------------------------
   // Run limit
   //------------------------------------------------------------
   always @(posedge clk_x) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("Summary: %0d checks, %0d errors", checks, errors);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      errors   = 0;
      checks   = 0;
      cycles   = 0;
      lfsr     = 32'h203c_167d;
      sat_mode = 1'b0;
      m_pair   = 0;
      m_bank   = 0;
      m_clear  = 1'b1;
      m_pend   = 1'b0;
      m_ovf_cos = 1'b0;
      m_ovf_sin = 1'b0;
      rst   = 1'b1;
      en_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      sw_i  = 1'b0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      bst_i = 1'b0;
      adr_i = '0;
      repeat (16) @(posedge clk_x);
      #1;
      rst = 1'b0;

      // Test 1 checks quiet outputs after reset
      check_value("reset ack", 0, int'(ack_o));
      check_flags("reset", 1'b0, 1'b0);
      quiet_bus(1'b1, 1'b0);
      quiet_bus(1'b0, 1'b1);

      // Test 2 accumulates into bank 0 with the swap request held until the wrap
      run_passes(20, 1'b0);
      swap_banks(1'b0, 1'b0);
      read_all("accumulate");
      check_flags("accumulate", m_ovf_cos, m_ovf_sin);

      // Test 3 runs gapped periods with the pulse on the wrap
      run_passes(20, 1'b1);
      swap_banks(1'b1, 1'b1);
      read_all("bank clear");
      // Second gapped period lands in the bank still holding the sums of test 2
      run_passes(20, 1'b1);
      swap_banks(1'b0, 1'b1);
      read_all("bank clear");

      // Test 4 reads back in burst mode
      read_burst("burst");

      // Test 5 has every product push cosine up and sine down
      sat_mode = 1'b1;
      run_passes(2100, 1'b0);
      swap_banks(1'b0, 1'b0);
      for (int i = 0; i < 2 * NPAIR; i++) begin
         read_word(addr_of(i), "saturation", addr_of(i) >= 5'd16 ? SAT_MIN : SAT_MAX);
      end
      check_flags("saturation", 1'b1, 1'b1);
      // Flags are sticky through normal traffic
      sat_mode = 1'b0;
      run_passes(3, 1'b1);
      repeat (4) slot(1'b0, 1'b0);
      check_flags("sticky", 1'b1, 1'b1);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: correlator.f
source/corr_pkg.sv
source/pair_select.sv
source/bank_ctrl.sv
source/cos_sin_mac.sv
source/visibility_ram.sv
source/vis_bus_read.sv
source/correlator_top.sv
tb/tb_clock.sv
tb/correlator_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the correlator testbench with Verilator and run it.
# The exit status comes from searching the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   --top-module correlator_tb -f correlator.f &&
./obj_dir/Vcorrelator_tb | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "correlator run ok" ||
{ echo "correlator run failed"; exit 1; }
